//--- Bender.yml
package:
  name: top_vga

sources:
  - common/vga_pkg.sv
  - verilog/vga_timing.sv
  - verilog/game_ctrl.sv
  - draw/draw_bg.sv
  - draw/draw_rect.sv
  - verilog/top_vga.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/top_vga_tb.sv

//--- common/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // Width of the pixel counters and of every screen position.
    localparam int POS_W = 11;

    // One pixel slot of the raster, passed from stage to stage each clock.
    typedef struct packed {
        logic [POS_W-1:0] hcount;
        logic [POS_W-1:0] vcount;
        logic             hsync;
        logic             vsync;
        logic             hblnk;
        logic             vblnk;
        logic [11:0]      rgb;    // 4 bits each of red, green and blue.
    } vga_t;

    typedef enum logic [1:0] {
        MENU       = 2'd0,
        GAME       = 2'd1,
        END_SCREEN = 2'd2
    } game_state_t;

    // Background colours, one per game state.
    localparam logic [11:0] COLOR_MENU = 12'h2_3_8;
    localparam logic [11:0] COLOR_GAME = 12'h4_a_4;
    localparam logic [11:0] COLOR_END  = 12'h8_2_2;

    // Sprite colours.
    localparam logic [11:0] COLOR_PLAYER   = 12'hf_f_0;
    localparam logic [11:0] COLOR_OBSTACLE = 12'h9_5_1;

    localparam logic [11:0] COLOR_BLANK = 12'h0_0_0; // Black outside the visible area.

endpackage

`default_nettype wire

//--- draw/draw_bg.sv
`default_nettype none

module draw_bg
    import vga_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  game_state_t game_state,
    input  vga_t        vga_in,
    output vga_t        vga_out
);

    logic [11:0] state_rgb;
    logic [11:0] rgb_nxt;

    always_comb begin
        case (game_state)
            MENU:       state_rgb = COLOR_MENU;
            GAME:       state_rgb = COLOR_GAME;
            END_SCREEN: state_rgb = COLOR_END;
            default:    state_rgb = COLOR_BLANK;
        endcase
    end

    // Nothing may be driven on the colour pins while the beam is blanked.
    assign rgb_nxt = (vga_in.hblnk || vga_in.vblnk) ? COLOR_BLANK : state_rgb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

//--- draw/draw_rect.sv
`default_nettype none

module draw_rect
    import vga_pkg::*;
#(
    parameter int          RECT_W = 32,
    parameter int          RECT_H = 32,
    parameter logic [11:0] COLOR  = 12'hf_f_f
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [POS_W-1:0] rect_x,
    input  logic [POS_W-1:0] rect_y,
    input  vga_t             vga_in,
    output vga_t             vga_out
);

    logic [POS_W:0] x_end;
    logic [POS_W:0] y_end;
    logic           in_x;
    logic           in_y;
    logic           hit;

    // The box is half open, so the far edges belong to the background.
    assign x_end = {1'b0, rect_x} + (POS_W + 1)'(RECT_W);
    assign y_end = {1'b0, rect_y} + (POS_W + 1)'(RECT_H);

    assign in_x = (vga_in.hcount >= rect_x) && ({1'b0, vga_in.hcount} < x_end);
    assign in_y = (vga_in.vcount >= rect_y) && ({1'b0, vga_in.vcount} < y_end);

    assign hit = enable && !vga_in.hblnk && !vga_in.vblnk && in_x && in_y;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_in;
            if (hit) begin
                vga_out.rgb <= COLOR;
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+testbench
common/vga_pkg.sv
verilog/vga_timing.sv
verilog/game_ctrl.sv
draw/draw_bg.sv
draw/draw_rect.sv
verilog/top_vga.sv
testbench/top_vga_tb.sv

//--- testbench/top_vga_ref.svh
// Controller state as the testbench model tracks it.
typedef struct packed {
    game_state_t      state;
    logic             active;
    logic [POS_W-1:0] x;
} ctrl_t;

// A pixel in the draw chain with the controller values that each stage sampled.
typedef struct packed {
    logic             valid;
    logic [POS_W-1:0] h;
    logic [POS_W-1:0] v;
    game_state_t      bg_state;
    logic             obst_on;
    logic             ply_on;
    logic [POS_W-1:0] ply_x;
} slot_t;

function automatic vga_t expected_pixel(input slot_t s);
    vga_t p;
    p.hcount = s.h;
    p.vcount = s.v;
    p.hsync  = (s.h >= H_ACTIVE + H_FP) && (s.h < H_ACTIVE + H_FP + H_SYNC);
    p.vsync  = (s.v >= V_ACTIVE + V_FP) && (s.v < V_ACTIVE + V_FP + V_SYNC);
    p.hblnk  = s.h >= H_ACTIVE;
    p.vblnk  = s.v >= V_ACTIVE;
    case (s.bg_state)
        MENU:       p.rgb = COLOR_MENU;
        GAME:       p.rgb = COLOR_GAME;
        END_SCREEN: p.rgb = COLOR_END;
        default:    p.rgb = COLOR_BLANK;
    endcase
    if (s.obst_on && s.h >= OBST_X && s.h < OBST_X + OBST_W
            && s.v >= OBST_Y && s.v < OBST_Y + OBST_H) begin
        p.rgb = COLOR_OBSTACLE;
    end
    // The player is painted after the obstacle and wins where they overlap.
    if (s.ply_on && s.h >= s.ply_x && s.h < s.ply_x + PLAYER_W
            && s.v >= PLAYER_Y && s.v < PLAYER_Y + PLAYER_H) begin
        p.rgb = COLOR_PLAYER;
    end
    if (p.hblnk || p.vblnk) p.rgb = COLOR_BLANK;
    return p;
endfunction

function automatic ctrl_t model_frame(input ctrl_t cur, input logic btn_rise,
                                      input logic frame_start, input logic left,
                                      input logic right);
    ctrl_t nxt;
    int    x;
    nxt = cur;
    x   = cur.x;
    case (cur.state)
        MENU: if (btn_rise) begin
            nxt.state  = GAME;
            nxt.active = 1'b1;
            nxt.x      = '0;
        end
        GAME: if (frame_start) begin
            if (right && !left) x = x + STEP;
            else if (left && !right) x = x - STEP;
            if (x < 0) x = 0;
            if (x > H_ACTIVE - PLAYER_W) x = H_ACTIVE - PLAYER_W;
            nxt.x = x[POS_W-1:0];
            if (x + PLAYER_W >= OBST_X) begin
                nxt.state  = END_SCREEN; // Contact with the obstacle.
                nxt.active = 1'b0;
            end
        end
        default: if (btn_rise) nxt.state = MENU;
    endcase
    return nxt;
endfunction

//--- testbench/top_vga_tb.sv
`default_nettype none

module top_vga_tb
    import vga_pkg::*;
();

    localparam int H_ACTIVE   = 16;
    localparam int H_FP       = 2;
    localparam int H_SYNC     = 2;
    localparam int H_BP       = 2;
    localparam int V_ACTIVE   = 8;
    localparam int V_FP       = 2;
    localparam int V_SYNC     = 2;
    localparam int V_BP       = 2;
    localparam int PLAYER_W   = 2;
    localparam int PLAYER_H   = 2;
    localparam int PLAYER_Y   = 5;
    localparam int OBST_X     = 10;
    localparam int OBST_Y     = 3;
    localparam int OBST_W     = 8;  // Reaches into the horizontal blanking.
    localparam int OBST_H     = 6;  // Reaches into the vertical blanking.
    localparam int STEP       = 2;
    localparam int H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int MAX_CYCLES = 40 * FRAME + 100; // The sequence needs under 30 frames.

    `include "top_vga_ref.svh"

    logic             clk;
    logic             rst;
    logic             buttondown;
    logic             stepleft;
    logic             stepright;
    logic             hs;
    logic             vs;
    logic [3:0]       r;
    logic [3:0]       g;
    logic [3:0]       b;
    vga_t             vga_out;
    game_state_t      game_state;
    logic [POS_W-1:0] player_x;

    ctrl_t            model;
    slot_t            stage_bg;
    slot_t            stage_obst;
    slot_t            stage_out;
    logic [POS_W-1:0] model_h;
    logic [POS_W-1:0] model_v;
    logic             model_btn_prev;
    logic [31:0]      lfsr;
    int               cycle_count;
    string            test_name;

    top_vga #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .PLAYER_W(PLAYER_W), .PLAYER_H(PLAYER_H), .PLAYER_Y(PLAYER_Y), .OBST_X(OBST_X),
        .OBST_Y(OBST_Y), .OBST_W(OBST_W), .OBST_H(OBST_H), .STEP(STEP)
    ) u_top_vga (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // Cycle model of the controller and of what each draw stage samples.
    always @(posedge clk or posedge rst) begin : model_step
        ctrl_t nxt;
        logic  frame_start;
        if (rst) begin
            model          = '{state: MENU, active: 1'b0, x: '0};
            stage_bg       = '0;
            stage_obst     = '0;
            stage_out      = '0;
            model_h        = '0;
            model_v        = '0;
            model_btn_prev = 1'b0;
        end else begin
            frame_start        = (model_h == '0) && (model_v == '0);
            stage_out          = stage_obst;
            stage_out.ply_on   = model.active;
            stage_out.ply_x    = model.x;
            stage_obst         = stage_bg;
            stage_obst.obst_on = model.active;
            stage_bg           = '{valid: 1'b1, h: model_h, v: model_v, bg_state: model.state,
                                   obst_on: 1'b0, ply_on: 1'b0, ply_x: '0};
            nxt = model_frame(model, buttondown && !model_btn_prev, frame_start,
                              stepleft, stepright);
            model          = nxt;
            model_btn_prev = buttondown;
            model_h        = (model_h == H_TOTAL - 1) ? '0 : model_h + 1'b1;
            if (model_h == '0) model_v = (model_v == V_TOTAL - 1) ? '0 : model_v + 1'b1;
        end
    end

    always @(negedge clk) begin : compare
        vga_t exp_pix;
        if (!rst && stage_out.valid) begin
            exp_pix = expected_pixel(stage_out);
            check_value("pixel struct", exp_pix, vga_out);
            check_value("pins", {exp_pix.hsync, exp_pix.vsync, exp_pix.rgb}, {hs, vs, r, g, b});
            check_value("game_state", model.state, game_state);
            check_value("player_x", model.x, player_x);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("The run timed out after %0d cycles.", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout.");
        end
    end

    task automatic drive_frame(input logic btn, input logic left, input logic right);
        buttondown = btn;
        stepleft   = left;
        stepright  = right;
        repeat (FRAME) @(negedge clk);
    endtask

    initial begin
        logic left;
        logic right;
        rst = 1'b1;
        buttondown = 1'b0;
        stepleft = 1'b0;
        stepright = 1'b0;
        lfsr = 32'h706f_604e;
        cycle_count = 0;
        test_name = "reset";
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_name = "menu_idle";
        drive_frame(1'b0, 1'b0, 1'b0);
        drive_frame(1'b0, 1'b0, 1'b0);
        test_name = "start_game";
        drive_frame(1'b1, 1'b0, 1'b0);
        drive_frame(1'b0, 1'b0, 1'b0);
        test_name = "random_steps";
        drive_frame(1'b0, 1'b1, 1'b0); // Left step at x = 0 hits the clamp.
        for (int i = 0; i < 14; i++) begin
            lfsr  = lfsr_step(lfsr);
            right = lfsr[0];
            lfsr  = lfsr_step(lfsr);
            left  = lfsr[0];
            drive_frame(1'b0, left, right);
        end
        test_name = "run_to_contact";
        while (model.state == GAME) drive_frame(1'b0, 1'b0, 1'b1);
        test_name = "end_screen";
        drive_frame(1'b0, 1'b0, 1'b0);
        test_name = "back_to_menu";
        drive_frame(1'b1, 1'b0, 1'b0);
        drive_frame(1'b0, 1'b0, 1'b0);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/game_ctrl.sv
`default_nettype none

module game_ctrl
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 800,
    parameter int PLAYER_W = 32,
    parameter int OBST_X   = 600,
    parameter int STEP     = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             buttondown,
    input  logic             stepleft,
    input  logic             stepright,
    input  vga_t             timing,
    output game_state_t      game_state,
    output logic             game_active,
    output logic [POS_W-1:0] player_x
);

    localparam logic [POS_W-1:0] X_MAX  = POS_W'(H_ACTIVE - PLAYER_W);
    localparam logic [POS_W-1:0] STEP_V = POS_W'(STEP);

    logic             btn_prev;
    logic             btn_rise;
    logic             frame_start;
    logic [POS_W:0]   x_sum;
    logic [POS_W-1:0] x_next;
    logic             contact;

    assign btn_rise    = buttondown && !btn_prev;
    assign frame_start = (timing.hcount == '0) && (timing.vcount == '0);
    assign x_sum       = {1'b0, player_x} + {1'b0, STEP_V}; // One spare bit for the clamp test.

    always_comb begin
        x_next = player_x;
        if (stepright && !stepleft) begin
            x_next = (x_sum > {1'b0, X_MAX}) ? X_MAX : x_sum[POS_W-1:0];
        end else if (stepleft && !stepright) begin
            x_next = (player_x < STEP_V) ? '0 : player_x - STEP_V;
        end
    end

    assign contact = ({1'b0, x_next} + (POS_W + 1)'(PLAYER_W)) >= (POS_W + 1)'(OBST_X);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_prev    <= 1'b0;
            game_state  <= MENU;
            game_active <= 1'b0;
            player_x    <= '0;
        end else begin
            btn_prev <= buttondown;
            case (game_state)
                MENU: if (btn_rise) begin
                    game_state  <= GAME;
                    game_active <= 1'b1;
                    player_x    <= '0;   // Each round starts at the left edge.
                end
                GAME: if (frame_start) begin
                    player_x <= x_next;
                    // The player touching the obstacle ends the round.
                    if (contact) begin
                        game_state  <= END_SCREEN;
                        game_active <= 1'b0;
                    end
                end
                END_SCREEN: if (btn_rise) game_state <= MENU;
                default: begin
                    game_state  <= MENU;
                    game_active <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/top_vga.sv
`default_nettype none

module top_vga
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 800,
    parameter int H_FP     = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BP     = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BP     = 23,
    parameter int PLAYER_W = 32,
    parameter int PLAYER_H = 48,
    parameter int PLAYER_Y = 500,
    parameter int OBST_X   = 600,
    parameter int OBST_Y   = 460,
    parameter int OBST_W   = 40,
    parameter int OBST_H   = 88,
    parameter int STEP     = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             buttondown,
    input  logic             stepleft,
    input  logic             stepright,
    output logic             hs,
    output logic             vs,
    output logic [3:0]       r,
    output logic [3:0]       g,
    output logic [3:0]       b,
    output vga_t             vga_out,
    output game_state_t      game_state,
    output logic [POS_W-1:0] player_x
);

    vga_t vga_tim;
    vga_t vga_bg;
    vga_t vga_obst;
    logic game_active;

    assign hs        = vga_out.hsync;
    assign vs        = vga_out.vsync;
    assign {r, g, b} = vga_out.rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_vga_timing (
        .clk,
        .rst,
        .vga(vga_tim)
    );

    game_ctrl #(
        .H_ACTIVE(H_ACTIVE), .PLAYER_W(PLAYER_W), .OBST_X(OBST_X), .STEP(STEP)
    ) u_game_ctrl (
        .clk,
        .rst,
        .buttondown,
        .stepleft,
        .stepright,
        .timing(vga_tim),
        .game_state,
        .game_active,
        .player_x
    );

    draw_bg u_draw_bg (
        .clk,
        .rst,
        .game_state,
        .vga_in(vga_tim),
        .vga_out(vga_bg)
    );

    draw_rect #(
        .RECT_W(OBST_W), .RECT_H(OBST_H), .COLOR(COLOR_OBSTACLE)
    ) u_obstacle (
        .clk,
        .rst,
        .enable(game_active),
        .rect_x(POS_W'(OBST_X)),
        .rect_y(POS_W'(OBST_Y)),
        .vga_in(vga_bg),
        .vga_out(vga_obst)
    );

    // Last in the chain, so the player is drawn over the obstacle.
    draw_rect #(
        .RECT_W(PLAYER_W), .RECT_H(PLAYER_H), .COLOR(COLOR_PLAYER)
    ) u_player (
        .clk,
        .rst,
        .enable(game_active),
        .rect_x(player_x),
        .rect_y(POS_W'(PLAYER_Y)),
        .vga_in(vga_obst),
        .vga_out(vga_out)
    );

endmodule

`default_nettype wire

//--- verilog/vga_timing.sv
`default_nettype none

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 800,
    parameter int H_FP     = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BP     = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BP     = 23
) (
    input  logic clk,
    input  logic rst,
    output vga_t vga
);

    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HS_START = H_ACTIVE + H_FP;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FP;
    localparam int VS_END   = VS_START + V_SYNC;

    logic [POS_W-1:0] h_next;
    logic [POS_W-1:0] v_next;

    // The counters live in the output struct itself, so the flags always
    // describe the same pixel as the counters next to them.
    always_comb begin
        h_next = vga.hcount + 1'b1;
        v_next = vga.vcount;
        if (vga.hcount == POS_W'(H_TOTAL - 1)) begin
            h_next = '0;
            if (vga.vcount == POS_W'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = vga.vcount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga <= '0;
        end else begin
            vga.hcount <= h_next;
            vga.vcount <= v_next;
            vga.hsync  <= (h_next >= HS_START) && (h_next < HS_END); // Active high.
            vga.vsync  <= (v_next >= VS_START) && (v_next < VS_END);
            vga.hblnk  <= h_next >= H_ACTIVE;
            vga.vblnk  <= v_next >= V_ACTIVE;
            vga.rgb    <= '0;  // The draw chain fills in the colour.
        end
    end

endmodule

`default_nettype wire
